// ==== mem_wb_top.f ====
src/mips_pkg.sv
src/data_memory.sv
src/mem_stage.sv
src/regfile_wb.sv
src/mem_wb_top.sv
verification/tb_mem_wb_top.sv

// ==== verification/tb_mem_wb_top.sv ====
/*
 * testbench for the MIPS memory and write-back subsystem
 * table-driven stimulus checked against a model of memory and registers
 */
module tb_mem_wb_top import mips_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// ====================
	// constants
	// ====================
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_ROWS = 17;
	localparam logic [31:0] SEED = 32'hb671;
	// reset, two register sweeps, the table and one drain cycle
	localparam int RUN_CYCLES = RESET_CYCLES + NUM_REGS + NUM_ROWS + 1 + NUM_REGS;
	localparam int WATCHDOG_NS = (RUN_CYCLES + 10) * CLK_PERIOD;

	// instruction kinds in the table
	typedef enum logic [1:0] {
		K_ALU    = 2'd0,
		K_LOAD   = 2'd1,
		K_STORE  = 2'd2,
		K_BRANCH = 2'd3
	} kind_e;

	// one table row
	typedef struct packed {
		kind_e               kind;
		logic                branch;
		logic                zero;
		logic [DMEM_AW-1:0]  addr;
		logic [1:0]          off;
		logic [REG_AW-1:0]   dest;
		logic                exp_pcsrc;
	} row_t;

	// ====================
	// signals
	// ====================
	logic                i_clk;
	logic                i_rst_n;
	ex_mem_t             i_ex_mem;
	logic [REG_AW-1:0]   i_rd_addr;
	logic                o_pcsrc;
	logic [DATA_W-1:0]   o_rd_data;

	row_t rows [NUM_ROWS];
	// reference copies of the data memory and register file
	logic [DATA_W-1:0] mem_model [DMEM_DEPTH];
	logic [DATA_W-1:0] reg_model [NUM_REGS];
	logic [31:0] rng_state;
	int errors;
	int checks;

	mem_wb_top dut0 (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_ex_mem  (i_ex_mem),
		.i_rd_addr (i_rd_addr),
		.o_pcsrc   (o_pcsrc),
		.o_rd_data (o_rd_data)
	);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	// ====================
	// helpers
	// ====================
	// xorshift32 step
	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic set_row(input int idx, input kind_e kind, input logic br,
		input logic zr, input logic [DMEM_AW-1:0] addr, input logic [1:0] off,
		input logic [REG_AW-1:0] dest, input logic exp_pcsrc);
		rows[idx].kind = kind;
		rows[idx].branch = br;
		rows[idx].zero = zr;
		rows[idx].addr = addr;
		rows[idx].off = off;
		rows[idx].dest = dest;
		rows[idx].exp_pcsrc = exp_pcsrc;
	endtask

	task automatic build_table();
		// store then load, load followed at once by an alu op
		set_row(0,  K_STORE,  1'b0, 1'b0, 8'h10, 2'd0, 5'd3,  1'b0);
		set_row(1,  K_LOAD,   1'b0, 1'b0, 8'h10, 2'd0, 5'd3,  1'b0);
		set_row(2,  K_ALU,    1'b0, 1'b1, 8'h00, 2'd0, 5'd4,  1'b0);
		// the four branch and zero combinations
		set_row(3,  K_BRANCH, 1'b1, 1'b0, 8'h00, 2'd0, 5'd6,  1'b0);
		set_row(4,  K_BRANCH, 1'b0, 1'b1, 8'h00, 2'd0, 5'd6,  1'b0);
		set_row(5,  K_BRANCH, 1'b1, 1'b1, 8'h00, 2'd0, 5'd6,  1'b1);
		set_row(6,  K_BRANCH, 1'b0, 1'b0, 8'h00, 2'd0, 5'd6,  1'b0);
		// byte offset differs between store and load
		set_row(7,  K_STORE,  1'b0, 1'b0, 8'h2a, 2'd3, 5'd7,  1'b0);
		set_row(8,  K_LOAD,   1'b0, 1'b0, 8'h2a, 2'd1, 5'd7,  1'b0);
		// r0 must stay zero
		set_row(9,  K_ALU,    1'b0, 1'b0, 8'h00, 2'd0, 5'd0,  1'b0);
		set_row(10, K_ALU,    1'b0, 1'b0, 8'h00, 2'd0, 5'd9,  1'b0);
		set_row(11, K_ALU,    1'b0, 1'b1, 8'h00, 2'd0, 5'd9,  1'b0);
		// memory edges
		set_row(12, K_STORE,  1'b0, 1'b0, 8'hff, 2'd2, 5'd31, 1'b0);
		set_row(13, K_STORE,  1'b0, 1'b0, 8'h00, 2'd0, 5'd1,  1'b0);
		set_row(14, K_LOAD,   1'b0, 1'b0, 8'hff, 2'd0, 5'd31, 1'b0);
		set_row(15, K_LOAD,   1'b0, 1'b0, 8'h00, 2'd3, 5'd0,  1'b0);
		set_row(16, K_ALU,    1'b0, 1'b0, 8'h00, 2'd0, 5'd5,  1'b0);
	endtask

	// drives one row, returns the value it would write back
	task automatic present_row(input row_t r, output logic [DATA_W-1:0] wb_value,
		output logic writes);
		ex_mem_t b;
		b = '0;
		b.branch = r.branch;
		b.zero = r.zero;
		b.dest_reg = r.dest;
		rng_state = next_rand(rng_state);
		b.alu_result = rng_state;
		rng_state = next_rand(rng_state);
		b.store_data = rng_state;
		case (r.kind)
			K_ALU: begin
				b.reg_write = 1'b1;
			end
			K_LOAD: begin
				b.mem_op = MEM_LOAD;
				b.mem_to_reg = 1'b1;
				b.reg_write = 1'b1;
				b.alu_result = '0;
				b.alu_result[DMEM_AW+1:0] = {r.addr, r.off};
			end
			K_STORE: begin
				b.mem_op = MEM_STORE;
				b.alu_result = '0;
				b.alu_result[DMEM_AW+1:0] = {r.addr, r.off};
			end
			default: begin
				b.mem_op = MEM_NONE;
			end
		endcase
		i_ex_mem = b;
		writes = b.reg_write;
		wb_value = (r.kind == K_LOAD) ? mem_model[r.addr] : b.alu_result;
		// store lands at the coming edge
		if (r.kind == K_STORE) begin
			mem_model[r.addr] = b.store_data;
		end
	endtask

	task automatic verify_pcsrc(input logic exp_pcsrc, input int row);
		checks++;
		if (o_pcsrc !== exp_pcsrc) begin
			errors++;
			$display("FAIL t=%0t: o_pcsrc at row %0d is %b, expected %b",
				$time, row, o_pcsrc, exp_pcsrc);
		end
	endtask

	task automatic compare_reg(input logic [REG_AW-1:0] addr, input logic [DATA_W-1:0] exp_data);
		checks++;
		if (o_rd_data !== exp_data) begin
			errors++;
			$display("FAIL t=%0t: r%0d reads %h, expected %h", $time, addr, o_rd_data, exp_data);
		end
	endtask

	// one register per cycle with an idle bundle
	task automatic sweep_regs();
		for (int a = 0; a < NUM_REGS; a++) begin
			@(negedge i_clk);
			i_ex_mem = '0;
			i_rd_addr = a[REG_AW-1:0];
			#1;
			verify_pcsrc(1'b0, -1);
			compare_reg(a[REG_AW-1:0], reg_model[a]);
		end
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		logic [DATA_W-1:0] wb_value;
		logic writes;
		logic [REG_AW-1:0] prev_dest;
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_ex_mem = '0;
		i_rd_addr = '0;
		errors = 0;
		checks = 0;
		rng_state = SEED;
		prev_dest = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			reg_model[i] = '0;
		end
		build_table();
		repeat (RESET_CYCLES) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;
		// all registers zero after reset
		sweep_regs();
		for (int k = 0; k < NUM_ROWS; k++) begin
			@(negedge i_clk);
			present_row(rows[k], wb_value, writes);
			// previous row sits in mem/wb, seen through write-through
			i_rd_addr = prev_dest;
			#1;
			verify_pcsrc(rows[k].exp_pcsrc, k);
			compare_reg(prev_dest, reg_model[prev_dest]);
			if (writes && (rows[k].dest != '0)) begin
				reg_model[rows[k].dest] = wb_value;
			end
			prev_dest = rows[k].dest;
		end
		// drain the last row
		@(negedge i_clk);
		i_ex_mem = '0;
		i_rd_addr = prev_dest;
		#1;
		verify_pcsrc(1'b0, NUM_ROWS);
		compare_reg(prev_dest, reg_model[prev_dest]);
		// values held after write-back
		sweep_regs();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== src/mem_wb_top.sv ====
/*
 * MIPS memory and write-back subsystem
 * data memory and memory stage share the execute bundle,
 * register file takes the combined result
 */
module mem_wb_top import mips_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// bundle from execute
	input  ex_mem_t             i_ex_mem,
	// register file read port
	input  logic [REG_AW-1:0]   i_rd_addr,
	// branch taken
	output logic                o_pcsrc,
	output logic [DATA_W-1:0]   o_rd_data
);

	// ====================
	// interconnect
	// ====================
	// word read from data memory
	logic [DATA_W-1:0] mem_rd_data;
	// mem/wb pipeline register
	mem_wb_t mem_wb;

	// ====================
	// hierarchy
	// ====================
	// word address from alu result, byte offset ignored
	data_memory u_data_memory (
		.i_clk     (i_clk),
		.i_mem_op  (i_ex_mem.mem_op),
		.i_addr    (i_ex_mem.alu_result[DMEM_AW+ADDR_LSB-1:ADDR_LSB]),
		.i_wr_data (i_ex_mem.store_data),
		.o_rd_data (mem_rd_data)
	);

	// branch resolve and mem/wb capture
	mem_stage u_mem_stage (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_ex_mem      (i_ex_mem),
		.i_mem_rd_data (mem_rd_data),
		.o_pcsrc       (o_pcsrc),
		.o_mem_wb      (mem_wb)
	);

	// result select and register file
	regfile_wb u_regfile_wb (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_mem_wb  (mem_wb),
		.i_rd_addr (i_rd_addr),
		.o_rd_data (o_rd_data)
	);

endmodule

// ==== src/regfile_wb.sv ====
/*
 * write-back and register file
 * selects the result, writes it to the 32-entry file,
 * register zero hard-wired, write-through read port
 */
module regfile_wb import mips_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// bundle from the memory stage
	input  mem_wb_t             i_mem_wb,
	// read port, stands in for decode
	input  logic [REG_AW-1:0]   i_rd_addr,
	output logic [DATA_W-1:0]   o_rd_data
);

	// ====================
	// signals
	// ====================
	// writable registers only, r0 has no storage
	logic [DATA_W-1:0] regs [1:NUM_REGS-1];

	// selected write-back value
	logic [DATA_W-1:0] wb_data;
	// write this cycle
	logic wr_en;
	// read hits the pending write
	logic rd_bypass;

	// ====================
	// result select
	// ====================
	// loaded word or alu result
	assign wb_data = i_mem_wb.mem_to_reg ? i_mem_wb.mem_data : i_mem_wb.alu_result;

	// r0 is never written
	assign wr_en = i_mem_wb.reg_write && (i_mem_wb.dest_reg != '0);

	// ====================
	// register array
	// ====================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			// all registers read 0 after reset
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[i_mem_wb.dest_reg] <= wb_data;
		end
	end

	// ====================
	// read port
	// ====================
	// same-cycle forward of the write value
	assign rd_bypass = wr_en && (i_rd_addr == i_mem_wb.dest_reg);

	always_comb begin
		if (i_rd_addr == '0) begin
			// hard-wired zero
			o_rd_data = '0;
		end else if (rd_bypass) begin
			// write-through
			o_rd_data = wb_data;
		end else begin
			o_rd_data = regs[i_rd_addr];
		end
	end

endmodule

// ==== src/mem_stage.sv ====
/*
 * memory-access stage
 * resolves the branch and registers the
 * memory-to-writeback bundle every cycle
 */
module mem_stage import mips_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// bundle from execute
	input  ex_mem_t             i_ex_mem,
	// word returned by the data memory
	input  logic [DATA_W-1:0]   i_mem_rd_data,
	// branch taken, to the fetch PC mux
	output logic                o_pcsrc,
	// registered bundle to write-back
	output mem_wb_t             o_mem_wb
);

	// ====================
	// signals
	// ====================
	// pipeline register
	mem_wb_t mem_wb_q;
	// value captured at the next edge
	mem_wb_t mem_wb_d;
	// destination is register zero
	logic dest_is_zero;

	// ====================
	// branch decision
	// ====================
	// taken when a branch sees a zero result
	assign o_pcsrc = i_ex_mem.branch & i_ex_mem.zero;

	// ====================
	// next bundle
	// ====================
	assign dest_is_zero = (i_ex_mem.dest_reg == '0);

	always_comb begin
		// control bits
		mem_wb_d.mem_to_reg = i_ex_mem.mem_to_reg;
		// a write to r0 dies here
		mem_wb_d.reg_write  = i_ex_mem.reg_write & ~dest_is_zero;
		// loaded word from memory
		mem_wb_d.mem_data   = i_mem_rd_data;
		// alu result passes through
		mem_wb_d.alu_result = i_ex_mem.alu_result;
		// target register
		mem_wb_d.dest_reg   = i_ex_mem.dest_reg;
	end

	// ====================
	// mem/wb register
	// ====================
	// holds the bundle for write-back
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mem_wb_q <= '0;
		end else begin
			// advances on every edge
			mem_wb_q <= mem_wb_d;
		end
	end

	assign o_mem_wb = mem_wb_q;

endmodule

// ==== src/data_memory.sv ====
/*
 * data memory
 * word-addressed RAM, combinational read,
 * write on the rising clock edge for stores
 */
module data_memory import mips_pkg::*; (
	input  logic                i_clk,
	// operation of the instruction in the stage
	input  mem_op_e             i_mem_op,
	// word address without the byte offset
	input  logic [DMEM_AW-1:0]  i_addr,
	input  logic [DATA_W-1:0]   i_wr_data,
	// word at the current address
	output logic [DATA_W-1:0]   o_rd_data
);

	// ====================
	// storage
	// ====================
	// one data word per address
	logic [DATA_W-1:0] mem [DMEM_DEPTH];

	// write strobe
	logic wr_en;

	// ====================
	// write port
	// ====================
	// only a store touches the array
	assign wr_en = (i_mem_op == MEM_STORE);

	always_ff @(posedge i_clk) begin
		if (wr_en) begin
			// new word visible from the next cycle on
			mem[i_addr] <= i_wr_data;
		end
	end

	// ====================
	// read port
	// ====================
	// asynchronous read for any operation
	// a load picks it up in the memory stage register
	always_comb begin
		o_rd_data = mem[i_addr];
	end

endmodule

// ==== src/mips_pkg.sv ====
/*
 * MIPS back-end shared definitions
 * word and register sizes, data memory depth,
 * memory operation codes and the pipeline bundles
 */
package mips_pkg;

	// ====================
	// sizes
	// ====================
	// machine word
	localparam int DATA_W = 32;
	// register index width and register count
	localparam int REG_AW = 5;
	localparam int NUM_REGS = 1 << REG_AW;
	// data memory word address width and depth
	localparam int DMEM_AW = 8;
	localparam int DMEM_DEPTH = 1 << DMEM_AW;
	// byte offset bits below the word address
	localparam int ADDR_LSB = 2;

	// ====================
	// opcodes
	// ====================
	// memory operation of the instruction in the stage
	typedef enum logic [1:0] {
		MEM_NONE  = 2'b00,
		MEM_LOAD  = 2'b01,
		MEM_STORE = 2'b10
	} mem_op_e;

	// ====================
	// pipeline bundles
	// ====================
	// execute to memory stage
	typedef struct packed {
		mem_op_e             mem_op;
		logic                branch;
		logic                zero;
		logic                mem_to_reg;
		logic                reg_write;
		logic [DATA_W-1:0]   alu_result;
		logic [DATA_W-1:0]   store_data;
		logic [REG_AW-1:0]   dest_reg;
	} ex_mem_t;

	// memory stage to write-back
	typedef struct packed {
		logic                mem_to_reg;
		logic                reg_write;
		logic [DATA_W-1:0]   mem_data;
		logic [DATA_W-1:0]   alu_result;
		logic [REG_AW-1:0]   dest_reg;
	} mem_wb_t;

endpackage
